//--- bench/tb_addsub.sv
// ##########################################################
// directed testbench for the add/subtract unit
// streams operands through the DUT, checks results against a
// reference model, then exercises the register port
// ##########################################################

module tb_addsub;
    import arith_pkg::*;
    import ctrl_regs_pkg::*;

    localparam logic [31:0] lfsr_taps = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

    logic                      clock;
    logic                      rst_n;
    logic                      in_valid;
    logic                      in_ready;
    logic [word_width-1:0]     in_a;
    logic [word_width-1:0]     in_b;
    logic                      out_valid;
    logic                      out_ready;
    logic [word_width-1:0]     out_result;
    logic                      out_carry;
    logic                      out_overflow;
    logic                      reg_wr_en;
    logic [reg_addr_width-1:0] reg_addr;
    logic [reg_data_width-1:0] reg_wr_data;
    logic [reg_data_width-1:0] reg_rd_data;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_state  = 32'h611d_2874;

    // mode last written to the control register, plus the flags and count it should show
    logic mode_sub;
    logic mode_cin;
    logic exp_carry_flag;
    logic exp_ovf_flag;
    int   exp_count;

    logic [word_width-1:0] src_a_q[$];
    logic [word_width-1:0] src_b_q[$];
    logic [word_width-1:0] exp_result_q[$];
    logic [1:0]            exp_flags_q[$]; // {overflow, carry}
    int                    exp_cycle_q[$]; // cycle in which the item was accepted

    addsub_top i_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_a         (in_a),
        .in_b         (in_b),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_result   (out_result),
        .out_carry    (out_carry),
        .out_overflow (out_overflow),
        .reg_wr_en    (reg_wr_en),
        .reg_addr     (reg_addr),
        .reg_wr_data  (reg_wr_data),
        .reg_rd_data  (reg_rd_data)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ##########################################################
    // helpers
    // ##########################################################

    // galois lfsr, one step for every bit handed out
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        logic        lsb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) lfsr_state = lfsr_state ^ lfsr_taps;
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    // returns {overflow, carry, result}
    function automatic logic [word_width+1:0] model_addsub(input logic [word_width-1:0] a,
                                                           input logic [word_width-1:0] b,
                                                           input logic sub,
                                                           input logic cin);
        logic [word_width-1:0] b_eff;
        logic [word_width:0]   full;
        logic                  ovf;
        b_eff = sub ? ~b : b;
        full  = {1'b0, a} + {1'b0, b_eff} + {{word_width{1'b0}}, cin};
        // same-sign operands that give a result of the other sign
        ovf = (a[word_width-1] == b_eff[word_width-1]) && (full[word_width-1] != a[word_width-1]);
        return {ovf, full};
    endfunction

    function automatic logic [31:0] expected_status();
        logic [31:0] word;
        word = '0;
        word[status_carry_bit] = exp_carry_flag;
        word[status_ovf_bit]   = exp_ovf_flag;
        return word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    task automatic write_reg(input logic [reg_addr_width-1:0] addr, input logic [31:0] data);
        @(negedge clock);
        reg_wr_en   = 1'b1;
        reg_addr    = addr;
        reg_wr_data = data;
        @(negedge clock);
        reg_wr_en = 1'b0;
    endtask

    task automatic read_reg(input logic [reg_addr_width-1:0] addr, input logic [31:0] expected,
                            input string name);
        @(negedge clock);
        reg_addr = addr;
        #1;
        check_value(name, reg_rd_data, expected);
    endtask

    task automatic set_mode(input logic sub, input logic cin);
        logic [31:0] data;
        data = '0;
        data[ctrl_sub_bit] = sub;
        data[ctrl_cin_bit] = cin;
        write_reg(addr_ctrl, data);
        mode_sub = sub;
        mode_cin = cin;
    endtask

    task automatic clear_status(input logic [31:0] mask);
        write_reg(addr_status, mask);
        if (mask[status_carry_bit]) exp_carry_flag = 1'b0;
        if (mask[status_ovf_bit]) exp_ovf_flag = 1'b0;
        read_reg(addr_status, expected_status(), "status");
    endtask

    task automatic push_pair(input logic [31:0] a, input logic [31:0] b);
        src_a_q.push_back(a);
        src_b_q.push_back(b);
    endtask

    task automatic push_random(input int n);
        repeat (n) push_pair(random_bits(32), random_bits(32));
    endtask

    // sends every queued operand pair and waits until all results are out
    task automatic run_stream(input bit random_ready, input bit check_latency);
        int                    limit;
        int                    cycles;
        int                    accept_cycle;
        bit                    accepted;
        bit                    stalled;
        bit                    occ_s1;
        bit                    occ_out;
        bit                    exp_in_ready;
        logic [31:0]           held_result;
        logic [1:0]            held_flags;
        logic [1:0]            flags;
        logic [word_width+1:0] expected;
        limit    = 50 + 8 * src_a_q.size();
        cycles   = 0;
        accepted = 1'b0;
        stalled  = 1'b0;
        occ_s1   = 1'b0;
        occ_out  = 1'b0;
        while ((src_a_q.size() > 0 || in_valid || exp_result_q.size() > 0) && cycles < limit) begin
            @(negedge clock);
            if (accepted || !in_valid) begin
                in_valid = src_a_q.size() > 0;
                if (in_valid) begin
                    in_a = src_a_q.pop_front();
                    in_b = src_b_q.pop_front();
                end
            end
            out_ready = random_ready ? (random_bits(1) != 0) : 1'b1;
            #1; // in_ready settles well before the next rising edge
            // the pipe may move when its output slot is empty or being drained
            exp_in_ready = !occ_out || out_ready;
            check_value("out_valid", 32'(out_valid), 32'(occ_out));
            check_value("in_ready", 32'(in_ready), 32'(exp_in_ready));
            if (stalled) begin
                check_value("out_valid", 32'(out_valid), 32'd1);
                check_value("out_result", out_result, held_result);
                check_value("out_flags", 32'({out_overflow, out_carry}), 32'(held_flags));
            end
            accepted = in_valid && in_ready;
            if (out_valid && out_ready) begin
                if (exp_result_q.size() == 0) begin
                    error_count++;
                    $display("result 0x%08h came out with no item in flight", out_result);
                end else begin
                    flags        = exp_flags_q.pop_front();
                    accept_cycle = exp_cycle_q.pop_front();
                    check_value("out_result", out_result, exp_result_q.pop_front());
                    check_value("out_carry", 32'(out_carry), 32'(flags[0]));
                    check_value("out_overflow", 32'(out_overflow), 32'(flags[1]));
                    if (check_latency) begin
                        check_value("latency", 32'(cycle_count - accept_cycle), 32'(pipe_latency));
                    end
                    exp_carry_flag = exp_carry_flag | flags[0];
                    exp_ovf_flag   = exp_ovf_flag | flags[1];
                    exp_count++;
                end
            end
            if (accepted) begin
                expected = model_addsub(in_a, in_b, mode_sub, mode_cin);
                exp_result_q.push_back(expected[word_width-1:0]);
                exp_flags_q.push_back(expected[word_width+1:word_width]);
                exp_cycle_q.push_back(cycle_count);
            end
            if (exp_in_ready) begin
                occ_out = occ_s1;
                occ_s1  = accepted;
            end
            stalled     = out_valid && !out_ready;
            held_result = out_result;
            held_flags  = {out_overflow, out_carry};
            cycle_count++;
            cycles++;
        end
        if (src_a_q.size() > 0 || in_valid || exp_result_q.size() > 0) begin
            error_count++;
            $display("stream timed out after %0d cycles with %0d results missing",
                     cycles, src_a_q.size() + exp_result_q.size());
            src_a_q.delete();
            src_b_q.delete();
            exp_result_q.delete();
            exp_flags_q.delete();
            exp_cycle_q.delete();
            in_valid = 1'b0;
        end
    endtask

    // ##########################################################
    // tests
    // ##########################################################

    task automatic test_reset();
        @(negedge clock);
        #1;
        check_value("out_valid", 32'(out_valid), 32'd0);
        read_reg(addr_ctrl, 32'd0, "ctrl");
        read_reg(addr_status, 32'd0, "status");
        read_reg(addr_count, 32'd0, "count");
    endtask

    task automatic test_add_stream();
        set_mode(1'b0, 1'b0);
        push_random(16);
        run_stream(1'b0, 1'b1);
    endtask

    task automatic test_sub_stream();
        set_mode(1'b1, 1'b1);
        push_pair(32'h8000_0000, 32'h0000_0001); // most negative minus one overflows
        push_pair(32'h1234_5678, 32'h1234_5678);
        push_pair(32'h0000_0000, 32'h0000_0001);
        push_random(6);
        run_stream(1'b0, 1'b1);
    endtask

    task automatic test_backpressure();
        set_mode(1'b0, 1'b1);
        push_random(20);
        run_stream(1'b1, 1'b0);
        // a duplicate would show up as a late out_valid
        repeat (3) begin
            @(negedge clock);
            #1;
            check_value("out_valid", 32'(out_valid), 32'd0);
        end
    endtask

    task automatic test_status_count();
        clear_status(32'h3);
        set_mode(1'b0, 1'b0);
        push_pair(32'hffff_ffff, 32'h0000_0001); // carry without overflow
        run_stream(1'b0, 1'b0);
        read_reg(addr_status, expected_status(), "status");
        push_pair(32'h7fff_ffff, 32'h0000_0001); // overflow without carry
        run_stream(1'b0, 1'b0);
        read_reg(addr_status, expected_status(), "status");
        push_pair(32'h0000_0001, 32'h0000_0001);
        run_stream(1'b0, 1'b0);
        read_reg(addr_status, expected_status(), "status");
        clear_status(32'(1) << status_carry_bit);
        clear_status(32'(1) << status_ovf_bit);
        read_reg(addr_count, 32'(exp_count % (1 << count_width)), "count");
        write_reg(addr_count, 32'h0000_5a5a);
        read_reg(addr_count, 32'(exp_count % (1 << count_width)), "count");
        write_reg(2'd3, 32'hffff_ffff);
        read_reg(2'd3, 32'd0, "unmapped");
        read_reg(addr_ctrl, 32'd0, "ctrl");
    endtask

    initial begin
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_a           = '0;
        in_b           = '0;
        out_ready      = 1'b0;
        reg_wr_en      = 1'b0;
        reg_addr       = '0;
        reg_wr_data    = '0;
        mode_sub       = 1'b0;
        mode_cin       = 1'b0;
        exp_carry_flag = 1'b0;
        exp_ovf_flag   = 1'b0;
        exp_count      = 0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        test_reset();
        test_add_stream();
        test_sub_stream();
        test_backpressure();
        test_status_count();

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_addsub \
    -f verilog.f -Mdir obj_dir -o tb_addsub > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_addsub > sim.log 2>&1 \
    || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "result: fail"; exit 1; } || { echo "result: pass"; exit 0; }

//--- src/addsub_ctrl_regs.sv
// ##########################################################
// control block beside the adder-subtractor pipe
// drives mode and carry-in, keeps sticky flags and a result counter
// single-cycle write port, combinational read port
// ##########################################################

module addsub_ctrl_regs (
    input  logic                                     clock,
    input  logic                                     rst_n,
    input  logic                                     reg_wr_en,
    input  logic [ctrl_regs_pkg::reg_addr_width-1:0] reg_addr,
    input  logic [ctrl_regs_pkg::reg_data_width-1:0] reg_wr_data,
    output logic [ctrl_regs_pkg::reg_data_width-1:0] reg_rd_data,
    output logic                                     cfg_sub,
    output logic                                     cfg_cin,
    input  logic                                     out_valid,
    input  logic                                     out_ready,
    input  logic                                     out_carry,
    input  logic                                     out_overflow
);
    import ctrl_regs_pkg::*;

    logic                   transfer;
    logic                   wr_ctrl;
    logic                   wr_status;
    logic                   status_carry;
    logic                   status_ovf;
    logic [count_width-1:0] count;

    assign transfer  = out_valid && out_ready; // one result leaves the pipe
    assign wr_ctrl   = reg_wr_en && (reg_addr == addr_ctrl);
    assign wr_status = reg_wr_en && (reg_addr == addr_status);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cfg_sub <= 1'b0;
            cfg_cin <= 1'b0;
        end else if (wr_ctrl) begin
            cfg_sub <= reg_wr_data[ctrl_sub_bit];
            cfg_cin <= reg_wr_data[ctrl_cin_bit];
        end
    end

    // a flag raised in the same cycle as its clear stays set
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            status_carry <= 1'b0;
            status_ovf   <= 1'b0;
        end else begin
            status_carry <= (status_carry && !(wr_status && reg_wr_data[status_carry_bit]))
                            || (transfer && out_carry);
            status_ovf   <= (status_ovf && !(wr_status && reg_wr_data[status_ovf_bit]))
                            || (transfer && out_overflow);
        end
    end

    // writes to the counter address fall through and are ignored
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= '0;
        end else if (transfer) begin
            count <= count + 1'b1; // wraps silently
        end
    end

    always_comb begin
        reg_rd_data = '0;
        case (reg_addr)
            addr_ctrl: begin
                reg_rd_data[ctrl_sub_bit] = cfg_sub;
                reg_rd_data[ctrl_cin_bit] = cfg_cin;
            end
            addr_status: begin
                reg_rd_data[status_carry_bit] = status_carry;
                reg_rd_data[status_ovf_bit]   = status_ovf;
            end
            addr_count: reg_rd_data[count_width-1:0] = count;
            default: reg_rd_data = '0; // address 3 is unmapped
        endcase
    end

    // the counter tracks output transfers and nothing else
    assert property (@(posedge clock) disable iff (!rst_n)
        !transfer |=> $stable(count));

endmodule

//--- src/addsub_pipe2.sv
// ##########################################################
// two-stage pipelined adder-subtractor with valid/ready streams
// lower half in stage 1, upper half in stage 2
// the whole pipe freezes while the output is held by back-pressure
// ##########################################################

module addsub_pipe2 (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic                             cfg_sub,
    input  logic                             cfg_cin,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [arith_pkg::word_width-1:0] in_a,
    input  logic [arith_pkg::word_width-1:0] in_b,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic [arith_pkg::word_width-1:0] out_result,
    output logic                             out_carry,
    output logic                             out_overflow
);
    import arith_pkg::*;

    logic advance;

    // lower half adder outputs
    logic [half_width-1:0] lo_sum;
    logic                  lo_carry;

    // stage 1 registers
    logic                  s1_valid;
    logic [half_width-1:0] s1_sum_lo;
    logic                  s1_carry;
    logic [half_width-1:0] s1_a_hi;
    logic [half_width-1:0] s1_b_hi;
    logic                  s1_sub;

    // upper half adder outputs
    logic [half_width-1:0] hi_sum;
    logic                  hi_carry;
    logic                  hi_overflow;

    // the pipe moves as one unit, so a free output slot frees every stage
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    // ######################################################
    // stage 1: lower half
    // ######################################################

    ripple_addsub #(
        .width (half_width)
    ) i_add_lo (
        .sub       (cfg_sub),
        .carry_in  (cfg_cin),
        .a         (in_a[half_width-1:0]),
        .b         (in_b[half_width-1:0]),
        .sum       (lo_sum),
        .carry_out (lo_carry),
        .overflow  ()
    );

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
        end
    end

    // mode is captured with the item and travels with it
    always_ff @(posedge clock) begin
        if (advance && in_valid) begin
            s1_sum_lo <= lo_sum;
            s1_carry  <= lo_carry;
            s1_a_hi   <= in_a[word_width-1:half_width];
            s1_b_hi   <= in_b[word_width-1:half_width];
            s1_sub    <= cfg_sub;
        end
    end

    // ######################################################
    // stage 2: upper half
    // ######################################################

    ripple_addsub #(
        .width (half_width)
    ) i_add_hi (
        .sub       (s1_sub),
        .carry_in  (s1_carry),
        .a         (s1_a_hi),
        .b         (s1_b_hi),
        .sum       (hi_sum),
        .carry_out (hi_carry),
        .overflow  (hi_overflow)
    );

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (advance && s1_valid) begin
            out_result   <= {hi_sum, s1_sum_lo};
            out_carry    <= hi_carry;     // carry out of the full word
            out_overflow <= hi_overflow;  // sign bit lives in the upper half
        end
    end

    // ######################################################
    // checks
    // ######################################################

    // a stalled result must not move or change
    assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_result)
            && $stable(out_carry) && $stable(out_overflow));

    // an accepted item reaches the output once the pipe moves again
    assert property (@(posedge clock) disable iff (!rst_n)
        $past(rst_n && in_valid && in_ready) && in_ready |=> out_valid);

endmodule

//--- src/addsub_top.sv
// ##########################################################
// top level of the add/subtract unit
// joins the register block and the two-stage pipe
// ##########################################################

module addsub_top (
    input  logic                                     clock,
    input  logic                                     rst_n,
    // operand stream
    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  logic [arith_pkg::word_width-1:0]         in_a,
    input  logic [arith_pkg::word_width-1:0]         in_b,
    // result stream
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output logic [arith_pkg::word_width-1:0]         out_result,
    output logic                                     out_carry,
    output logic                                     out_overflow,
    // register port
    input  logic                                     reg_wr_en,
    input  logic [ctrl_regs_pkg::reg_addr_width-1:0] reg_addr,
    input  logic [ctrl_regs_pkg::reg_data_width-1:0] reg_wr_data,
    output logic [ctrl_regs_pkg::reg_data_width-1:0] reg_rd_data
);

    logic cfg_sub; // from the control register into stage 1
    logic cfg_cin;

    addsub_ctrl_regs i_regs (
        .clock        (clock),
        .rst_n        (rst_n),
        .reg_wr_en    (reg_wr_en),
        .reg_addr     (reg_addr),
        .reg_wr_data  (reg_wr_data),
        .reg_rd_data  (reg_rd_data),
        .cfg_sub      (cfg_sub),
        .cfg_cin      (cfg_cin),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_carry    (out_carry),
        .out_overflow (out_overflow)
    );

    // the register block watches the same result handshake the outside sees
    addsub_pipe2 i_pipe (
        .clock        (clock),
        .rst_n        (rst_n),
        .cfg_sub      (cfg_sub),
        .cfg_cin      (cfg_cin),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_a         (in_a),
        .in_b         (in_b),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_result   (out_result),
        .out_carry    (out_carry),
        .out_overflow (out_overflow)
    );

endmodule

//--- src/arith_pkg.sv
// ##########################################################
// datapath constants for the pipelined adder-subtractor
// import into any block that sizes operands or results
// ##########################################################

package arith_pkg;

    // ######################################################
    // word geometry
    // ######################################################

    // operand and result width, must stay even so both halves match
    localparam int word_width = 32;

    localparam int half_width = word_width / 2; // one half per pipeline stage

    // ######################################################
    // timing
    // ######################################################

    // clock edges from the handshake cycle to out_valid without stall
    // the edge that accepts the item counts as the first one
    localparam int pipe_latency = 2;

endpackage

//--- src/ctrl_regs_pkg.sv
// ##########################################################
// register map of the adder-subtractor control block
// addresses, field positions and widths for the register port
// ##########################################################

package ctrl_regs_pkg;

    localparam int reg_addr_width = 2;
    localparam int reg_data_width = 32;

    // ######################################################
    // addresses
    // ######################################################

    localparam logic [reg_addr_width-1:0] addr_ctrl   = 2'd0; // mode and carry-in
    localparam logic [reg_addr_width-1:0] addr_status = 2'd1; // sticky flags, write 1 to clear
    localparam logic [reg_addr_width-1:0] addr_count  = 2'd2; // completed results, read only

    // ######################################################
    // fields
    // ######################################################

    localparam int ctrl_sub_bit = 0;
    localparam int ctrl_cin_bit = 1;

    localparam int status_carry_bit = 0;
    localparam int status_ovf_bit   = 1;

    // the counter wraps at this width
    localparam int count_width = 16;

endpackage

//--- src/ripple_addsub.sv
// ##########################################################
// combinational ripple-carry adder-subtractor
// sum = a + (sub ? ~b : b) + carry_in, with carry-out and overflow
// ##########################################################

module ripple_addsub #(
    parameter int width = 16
) (
    input  logic             sub,
    input  logic             carry_in,
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    output logic [width-1:0] sum,
    output logic             carry_out,
    output logic             overflow
);

    logic [width-1:0] b_eff;
    logic [width:0]   carry; // carry[i] enters bit i

    // subtraction relies on carry_in being 1 for a two's complement result
    assign b_eff = b ^ {width{sub}};

    always_comb begin
        carry[0] = carry_in;
        for (int i = 0; i < width; i++) begin
            sum[i]       = a[i] ^ b_eff[i] ^ carry[i];
            carry[i + 1] = (a[i] & b_eff[i]) | (carry[i] & (a[i] ^ b_eff[i]));
        end
    end

    assign carry_out = carry[width];

    // signed overflow when the carry into the sign bit differs from the one out of it
    assign overflow = carry[width] ^ carry[width - 1];

endmodule

//--- verilog.f
src/arith_pkg.sv
src/ctrl_regs_pkg.sv
src/ripple_addsub.sv
src/addsub_pipe2.sv
src/addsub_ctrl_regs.sv
src/addsub_top.sv
bench/tb_addsub.sv
